// File: hw/event_unit_config.svh
// build-time sizing of the event unit
// every module reads these macros directly and takes no parameters,
// so a change here applies to the whole unit at once
// limits: 1 to 8 cores, at most 8 barriers, SoC event IDs of at most 31 bits
`ifndef EVENT_UNIT_CONFIG_SVH
`define EVENT_UNIT_CONFIG_SVH

// number of cores, each with its own register port and clock enable
`define EU_NB_CORES 4

// number of hardware barriers, event lines 8 and up
`define EU_NB_BARR 2

// entries in the SoC peripheral event FIFO
`define EU_FIFO_DEPTH 4

// width of one SoC peripheral event ID
`define EU_EVT_ID_W 8

`endif

// File: hw/event_unit_pkg.sv
// shared event unit types and the fixed 32-bit event-line map of a core
// widths follow the macros in event_unit_config.svh
// lines 7:0 software, 15:8 barriers, 16 SoC FIFO, 31:17 cluster events 14:0
`include "event_unit_config.svh"

package event_unit_pkg;

  typedef logic [`EU_NB_CORES-1:0] core_mask_t;
  typedef logic [31:0]             event_lines_t;
  typedef logic [2:0]              barr_id_t;
  typedef logic [2:0]              sw_evt_id_t;
  typedef logic [`EU_EVT_ID_W-1:0] evt_id_t;

  localparam int unsigned NB_SW_EVT       = 8;
  localparam int unsigned EVT_SW_LSB      = 0;
  localparam int unsigned EVT_BARR_LSB    = 8;
  localparam int unsigned EVT_FIFO_BIT    = 16;
  localparam int unsigned EVT_CLUSTER_LSB = 17;
  // cluster event input bit 15 has no line left in the map
  localparam int unsigned NB_CLUSTER_EVT  = 32 - EVT_CLUSTER_LSB;

  // SLEEP is only reached by a blocking wait read
  typedef enum logic [1:0] {
    IDLE,
    ACK,
    SLEEP
  } core_state_e;

endpackage

// File: hw/eu_bus_pkg.sv
// four-phase register port used by the core ports and the peripheral port
// req, we, addr and wdata stay stable from req rise until ack rises
// unmapped addresses read as 0 and ignore writes
package eu_bus_pkg;

  typedef logic [3:0] eu_addr_t;

  typedef struct packed {
    logic        req;
    logic        we;
    eu_addr_t    addr;
    logic [31:0] wdata;
  } eu_bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } eu_bus_rsp_t;

  // core port register map
  localparam eu_addr_t ADDR_MASK      = 4'd0;
  localparam eu_addr_t ADDR_BUFFER    = 4'd1;
  localparam eu_addr_t ADDR_CLEAR     = 4'd2;
  localparam eu_addr_t ADDR_WAIT      = 4'd3;
  localparam eu_addr_t ADDR_SW_TRIG   = 4'd4;
  localparam eu_addr_t ADDR_BARR_TRIG = 4'd5;

  // peripheral port map, barrier b owns ADDR_BARR_MASK0 + b
  localparam eu_addr_t ADDR_BARR_MASK0 = 4'd0;
  localparam eu_addr_t ADDR_FIFO_POP   = 4'd8;

endpackage

// File: hw/event_unit_core.sv
// per-core slice of the event unit behind a four-phase register port
// non-blocking accesses ack one cycle after req, ack drops one cycle after req falls
// a wait read with no unmasked event pending holds ack and the clock enable low
// the software trigger target mask is wdata[15:8], cut to the core count
`timescale 1ns/100ps

module event_unit_core (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  eu_bus_pkg::eu_bus_req_t      bus_req_i,
  output eu_bus_pkg::eu_bus_rsp_t      bus_rsp_o,
  input  event_unit_pkg::event_lines_t event_lines_i,
  output logic                         sw_trig_o,
  output event_unit_pkg::sw_evt_id_t   sw_trig_id_o,
  output event_unit_pkg::core_mask_t   sw_trig_mask_o,
  output logic                         barr_trig_o,
  output event_unit_pkg::barr_id_t     barr_trig_id_o,
  output logic                         clock_en_o
);

  import event_unit_pkg::*;
  import eu_bus_pkg::*;

  core_state_e  state_q, state_d;
  event_lines_t mask_q, buffer_q, masked, buf_clr;
  logic [31:0]  rdata_q, rdata_d;
  logic         ack_rise, is_wr, is_wait;

  assign masked  = buffer_q & mask_q;
  assign is_wr   = bus_req_i.we;
  assign is_wait = !bus_req_i.we && (bus_req_i.addr == ADDR_WAIT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (bus_req_i.req) begin
          // nothing pending on a wait read, so the core goes to sleep
          state_d = (is_wait && (masked == '0)) ? SLEEP : ACK;
        end
      end
      SLEEP: begin
        if (masked != '0) begin
          state_d = ACK;
        end
      end
      ACK: begin
        if (!bus_req_i.req) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // every side effect of an access is tied to the cycle that raises ack
  assign ack_rise = (state_d == ACK) && (state_q != ACK);

  always_comb begin
    rdata_d = '0;
    buf_clr = '0;
    if (!is_wr) begin
      case (bus_req_i.addr)
        ADDR_MASK:   rdata_d = mask_q;
        ADDR_BUFFER: rdata_d = buffer_q;
        ADDR_WAIT:   rdata_d = masked;
        default:     rdata_d = '0;
      endcase
    end
    if (ack_rise && is_wait) begin
      buf_clr = masked;
    end
    if (ack_rise && is_wr && (bus_req_i.addr == ADDR_CLEAR)) begin
      buf_clr = bus_req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      mask_q      <= '0;
      buffer_q    <= '0;
      sw_trig_o   <= 1'b0;
      barr_trig_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      sw_trig_o   <= ack_rise && is_wr && (bus_req_i.addr == ADDR_SW_TRIG);
      barr_trig_o <= ack_rise && is_wr && (bus_req_i.addr == ADDR_BARR_TRIG);
      if (ack_rise && is_wr && (bus_req_i.addr == ADDR_MASK)) begin
        mask_q <= bus_req_i.wdata;
      end
      // a line that is high at this edge wins over a clear of the same bit
      buffer_q <= (buffer_q & ~buf_clr) | event_lines_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ack_rise) begin
      rdata_q        <= rdata_d;
      sw_trig_id_o   <= bus_req_i.wdata[2:0];
      sw_trig_mask_o <= bus_req_i.wdata[8 +: $bits(core_mask_t)];
      barr_trig_id_o <= bus_req_i.wdata[2:0];
    end
  end

  assign bus_rsp_o.ack   = (state_q == ACK);
  assign bus_rsp_o.rdata = rdata_q;
  assign clock_en_o      = (state_q != SLEEP);

endmodule

// File: hw/hw_barrier_unit.sv
// one hardware barrier with a programmable participant mask
// only arrivals from participants are counted
// release is a one-cycle pulse and never fires while the mask is 0
`timescale 1ns/100ps

module hw_barrier_unit (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       cfg_we_i,
  input  event_unit_pkg::core_mask_t cfg_wdata_i,
  input  event_unit_pkg::core_mask_t arrive_i,
  output event_unit_pkg::core_mask_t part_mask_o,
  output logic                       release_o
);

  import event_unit_pkg::*;

  core_mask_t part_q, arrived_q;
  logic       done;

  assign done = (part_q != '0) && (arrived_q == part_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      part_q    <= '0;
      arrived_q <= '0;
      release_o <= 1'b0;
    end else begin
      release_o <= done;
      if (cfg_we_i) begin
        // a new participant set restarts the barrier
        part_q    <= cfg_wdata_i;
        arrived_q <= '0;
      end else if (done) begin
        // arrivals in the release cycle already count for the next round
        arrived_q <= arrive_i & part_q;
      end else begin
        arrived_q <= arrived_q | (arrive_i & part_q);
      end
    end
  end

  assign part_mask_o = part_q;

endmodule

// File: hw/soc_periph_fifo.sv
// FIFO of SoC peripheral event IDs with a valid/ready input
// ready is low exactly while the FIFO is full
// pop_data_o shows the head as {valid, zeros, id}, all zero when empty
`timescale 1ns/100ps
`include "event_unit_config.svh"

module soc_periph_fifo (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    evt_valid_i,
  output logic                    evt_ready_o,
  input  event_unit_pkg::evt_id_t evt_id_i,
  input  logic                    pop_i,
  output logic [31:0]             pop_data_o,
  output logic                    not_empty_o
);

  import event_unit_pkg::*;

  localparam int unsigned DEPTH = `EU_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  evt_id_t          mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push, pop;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign evt_ready_o = (count_q != CNT_W'(DEPTH));
  assign not_empty_o = (count_q != '0);
  assign push        = evt_valid_i && evt_ready_o;
  assign pop         = pop_i && not_empty_o;

  always_comb begin
    pop_data_o = '0;
    if (not_empty_o) begin
      pop_data_o[31]                  = 1'b1;
      pop_data_o[$bits(evt_id_t)-1:0] = mem_q[rd_ptr_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= evt_id_i;
    end
  end

endmodule

// File: hw/eu_periph_demux.sv
// shared four-phase peripheral port of the event unit
// ack rises one cycle after req, the write or pop strobe fires in that same cycle
// barrier masks above the barrier count read as 0 and ignore writes
`timescale 1ns/100ps
`include "event_unit_config.svh"

module eu_periph_demux (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  eu_bus_pkg::eu_bus_req_t                       periph_req_i,
  output eu_bus_pkg::eu_bus_rsp_t                       periph_rsp_o,
  output logic [`EU_NB_BARR-1:0]                        barr_cfg_we_o,
  output event_unit_pkg::core_mask_t                    barr_cfg_wdata_o,
  input  event_unit_pkg::core_mask_t [`EU_NB_BARR-1:0]  barr_mask_i,
  output logic                                          fifo_pop_o,
  input  logic [31:0]                                   fifo_data_i
);

  import event_unit_pkg::*;
  import eu_bus_pkg::*;

  core_state_e            state_q;
  logic                   start;
  logic [`EU_NB_BARR-1:0] barr_sel;
  logic [31:0]            rdata_d, rdata_q;

  assign start = (state_q == IDLE) && periph_req_i.req;

  always_comb begin
    barr_sel = '0;
    rdata_d  = '0;
    for (int b = 0; b < `EU_NB_BARR; b++) begin
      if (periph_req_i.addr == eu_addr_t'(ADDR_BARR_MASK0 + b)) begin
        barr_sel[b] = 1'b1;
        rdata_d     = 32'(barr_mask_i[b]);
      end
    end
    if (periph_req_i.addr == ADDR_FIFO_POP) begin
      rdata_d = fifo_data_i;
    end
    if (periph_req_i.we) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= IDLE;
      barr_cfg_we_o <= '0;
      fifo_pop_o    <= 1'b0;
    end else begin
      if (start) begin
        state_q <= ACK;
      end else if ((state_q == ACK) && !periph_req_i.req) begin
        state_q <= IDLE;
      end
      barr_cfg_we_o <= (start && periph_req_i.we) ? barr_sel : '0;
      fifo_pop_o    <= start && !periph_req_i.we && (periph_req_i.addr == ADDR_FIFO_POP);
    end
  end

  // rdata is taken before the pop, so it carries the head that the pop removes
  always_ff @(posedge clk_i) begin
    if (start) begin
      rdata_q          <= rdata_d;
      barr_cfg_wdata_o <= periph_req_i.wdata[$bits(core_mask_t)-1:0];
    end
  end

  assign periph_rsp_o.ack   = (state_q == ACK);
  assign periph_rsp_o.rdata = rdata_q;

endmodule

// File: hw/event_unit_top.sv
// cluster event unit with one register port per core and a shared peripheral port
// hardware events enter as a 16-bit cluster field per core and bit 15 is dropped
// sizes come from event_unit_config.svh
`timescale 1ns/100ps
`include "event_unit_config.svh"

module event_unit_top (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  eu_bus_pkg::eu_bus_req_t [`EU_NB_CORES-1:0]  core_req_i,
  output eu_bus_pkg::eu_bus_rsp_t [`EU_NB_CORES-1:0]  core_rsp_o,
  input  eu_bus_pkg::eu_bus_req_t                     periph_req_i,
  output eu_bus_pkg::eu_bus_rsp_t                     periph_rsp_o,
  input  logic                                        soc_evt_valid_i,
  output logic                                        soc_evt_ready_o,
  input  event_unit_pkg::evt_id_t                     soc_evt_id_i,
  input  logic [`EU_NB_CORES-1:0][15:0]               cluster_events_i,
  output event_unit_pkg::core_mask_t                  core_clock_en_o
);

  import event_unit_pkg::*;

  localparam int unsigned NC = `EU_NB_CORES;
  localparam int unsigned NB = `EU_NB_BARR;

  logic [NC-1:0]                sw_trig, barr_trig;
  sw_evt_id_t [NC-1:0]          sw_trig_id;
  core_mask_t [NC-1:0]          sw_trig_mask;
  barr_id_t [NC-1:0]            barr_trig_id;
  logic [NC-1:0][NB_SW_EVT-1:0] sw_events;
  event_lines_t [NC-1:0]        event_lines;
  core_mask_t [NB-1:0]          barr_arrive, barr_mask;
  logic [NB-1:0]                barr_release, barr_cfg_we;
  core_mask_t                   barr_cfg_wdata;
  logic                         fifo_pop, fifo_not_empty;
  logic [31:0]                  fifo_data;

  // software events from all cores merge per target, barrier triggers decode per barrier
  always_comb begin
    sw_events   = '0;
    barr_arrive = '0;
    for (int c = 0; c < NC; c++) begin
      for (int t = 0; t < NC; t++) begin
        if (sw_trig[c] && sw_trig_mask[c][t]) begin
          sw_events[t][sw_trig_id[c]] = 1'b1;
        end
      end
      for (int b = 0; b < NB; b++) begin
        if (barr_trig[c] && (barr_trig_id[c] == barr_id_t'(b))) begin
          barr_arrive[b][c] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NC; c++) begin
      event_lines[c] = '0;
      event_lines[c][EVT_SW_LSB +: NB_SW_EVT] = sw_events[c];
      // a release only reaches the cores that take part in that barrier
      for (int b = 0; b < NB; b++) begin
        event_lines[c][EVT_BARR_LSB + b] = barr_release[b] & barr_mask[b][c];
      end
      event_lines[c][EVT_FIFO_BIT] = fifo_not_empty;
      event_lines[c][EVT_CLUSTER_LSB +: NB_CLUSTER_EVT] = cluster_events_i[c][NB_CLUSTER_EVT-1:0];
    end
  end

  for (genvar c = 0; c < NC; c++) begin : gen_core
    event_unit_core i_core (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .bus_req_i      (core_req_i[c]),
      .bus_rsp_o      (core_rsp_o[c]),
      .event_lines_i  (event_lines[c]),
      .sw_trig_o      (sw_trig[c]),
      .sw_trig_id_o   (sw_trig_id[c]),
      .sw_trig_mask_o (sw_trig_mask[c]),
      .barr_trig_o    (barr_trig[c]),
      .barr_trig_id_o (barr_trig_id[c]),
      .clock_en_o     (core_clock_en_o[c])
    );
  end

  for (genvar b = 0; b < NB; b++) begin : gen_barrier
    hw_barrier_unit i_barrier (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_we_i    (barr_cfg_we[b]),
      .cfg_wdata_i (barr_cfg_wdata),
      .arrive_i    (barr_arrive[b]),
      .part_mask_o (barr_mask[b]),
      .release_o   (barr_release[b])
    );
  end

  soc_periph_fifo i_soc_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .evt_valid_i (soc_evt_valid_i),
    .evt_ready_o (soc_evt_ready_o),
    .evt_id_i    (soc_evt_id_i),
    .pop_i       (fifo_pop),
    .pop_data_o  (fifo_data),
    .not_empty_o (fifo_not_empty)
  );

  eu_periph_demux i_periph_demux (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .periph_req_i     (periph_req_i),
    .periph_rsp_o     (periph_rsp_o),
    .barr_cfg_we_o    (barr_cfg_we),
    .barr_cfg_wdata_o (barr_cfg_wdata),
    .barr_mask_i      (barr_mask),
    .fifo_pop_o       (fifo_pop),
    .fifo_data_i      (fifo_data)
  );

endmodule

// File: tests/tb_event_unit.sv
// self-checking testbench for the cluster event unit
// expects the default sizes of event_unit_config.svh and at least two cores
// inputs change 2 ns after a rising edge, outputs are sampled at the same point
// the run stops at the first mismatch or timeout
`timescale 1ns/100ps
`include "event_unit_config.svh"

module tb_event_unit;

  import event_unit_pkg::*;
  import eu_bus_pkg::*;

  localparam int NC          = `EU_NB_CORES;
  localparam int PERIPH      = NC;
  localparam int ACK_LIMIT   = 20;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRIVE_DLY   = 2;

  logic                           clk, rst;
  eu_bus_req_t [NC-1:0]           core_req;
  eu_bus_rsp_t [NC-1:0]           core_rsp;
  eu_bus_req_t                    periph_req;
  eu_bus_rsp_t                    periph_rsp;
  logic                           soc_valid, soc_ready;
  evt_id_t                        soc_id;
  logic [NC-1:0][15:0]            cluster_ev;
  core_mask_t                     core_clock_en;
  logic [NC-1:0]                  wait_pending;
  logic [31:0]                    lfsr_q;
  event_lines_t                   exp_buf [NC];

  event_unit_top i_dut (
    .clk_i            (clk),
    .rst_i            (rst),
    .core_req_i       (core_req),
    .core_rsp_o       (core_rsp),
    .periph_req_i     (periph_req),
    .periph_rsp_o     (periph_rsp),
    .soc_evt_valid_i  (soc_valid),
    .soc_evt_ready_o  (soc_ready),
    .soc_evt_id_i     (soc_id),
    .cluster_events_i (cluster_ev),
    .core_clock_en_o  (core_clock_en)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  always_comb begin
    for (int c = 0; c < NC; c++) begin
      wait_pending[c] = core_req[c].req && !core_req[c].we &&
                        (core_req[c].addr == ADDR_WAIT);
    end
  end

  // a core may only have its clock gated while its own wait read is outstanding
  assert property (@(posedge clk) disable iff (rst) (~core_clock_en & ~wait_pending) == '0)
    else abort_run($sformatf("ERROR at %0t ns: clock gated with no wait read pending", $time));

  // 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // port index NC stands for the shared peripheral port
  function automatic logic port_ack(input int p);
    return (p < NC) ? core_rsp[p].ack : periph_rsp.ack;
  endfunction

  task automatic drive_port(input int p, input eu_bus_req_t r);
    if (p < NC) begin
      core_req[p] = r;
    end else begin
      periph_req = r;
    end
  endtask

  task automatic bus_access(input int p, input logic wr, input eu_addr_t a,
                            input logic [31:0] d, input int limit, output logic [31:0] rd);
    eu_bus_req_t r;
    int          n;
    r.req   = 1'b1;
    r.we    = wr;
    r.addr  = a;
    r.wdata = d;
    drive_port(p, r);
    n = 0;
    while (!port_ack(p)) begin
      next_cycle();
      n++;
      if (n > limit) begin
        abort_run($sformatf("port %0d never raised ack after req", p));
      end
    end
    rd = (p < NC) ? core_rsp[p].rdata : periph_rsp.rdata;
    // only a wait read on a core port may take longer than one cycle
    if (!(p < NC && !wr && a == ADDR_WAIT)) begin
      check_value($sformatf("ack latency on port %0d", p), n, 1);
    end
    r.req = 1'b0;
    drive_port(p, r);
    n = 0;
    while (port_ack(p)) begin
      next_cycle();
      n++;
      if (n > limit) begin
        abort_run($sformatf("port %0d kept ack high after req fell", p));
      end
    end
    check_value($sformatf("ack release latency on port %0d", p), n, 1);
  endtask

  task automatic write_reg(input int p, input eu_addr_t a, input logic [31:0] d);
    logic [31:0] unused;
    bus_access(p, 1'b1, a, d, ACK_LIMIT, unused);
  endtask

  task automatic expect_reg(input int p, input eu_addr_t a, input logic [31:0] exp,
                            input string what);
    logic [31:0] rd;
    bus_access(p, 1'b0, a, '0, ACK_LIMIT, rd);
    check_value(what, rd, exp);
  endtask

  // lets pending pulses land in the buffers and then compares every core
  task automatic check_buffers();
    repeat (3) next_cycle();
    for (int c = 0; c < NC; c++) begin
      expect_reg(c, ADDR_BUFFER, exp_buf[c], $sformatf("buffer of core %0d", c));
    end
  endtask

  task automatic clear_all();
    for (int c = 0; c < NC; c++) begin
      write_reg(c, ADDR_CLEAR, 32'hffff_ffff);
      exp_buf[c] = '0;
    end
  endtask

  initial begin
    logic [31:0] rd, wdata;
    int          c, w, s, b, k, n, left;
    sw_evt_id_t  idx;
    core_mask_t  part;
    evt_id_t     fifo_q [$];
    lfsr_q     = 32'h1f2b4697;
    rst        = 1'b1;
    core_req   = '0;
    periph_req = '0;
    soc_valid  = 1'b0;
    soc_id     = '0;
    cluster_ev = '0;
    for (int i = 0; i < NC; i++) begin
      exp_buf[i] = '0;
    end
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    // reset state and mask readback
    check_value("clock enables after reset", core_clock_en, {NC{1'b1}});
    check_value("SoC ready after reset", soc_ready, 1);
    for (int i = 0; i < NC; i++) begin
      expect_reg(i, ADDR_MASK, '0, $sformatf("mask of core %0d after reset", i));
      expect_reg(i, ADDR_BUFFER, '0, $sformatf("buffer of core %0d after reset", i));
    end
    c     = rand_bits(3) % NC;
    wdata = rand_bits(32);
    write_reg(c, ADDR_MASK, wdata);
    expect_reg(c, ADDR_MASK, wdata, "mask readback");

    // software events and then partial clears
    for (int i = 0; i < 4; i++) begin
      c    = rand_bits(3) % NC;
      idx  = sw_evt_id_t'(rand_bits(3));
      part = core_mask_t'(rand_bits(NC));
      write_reg(c, ADDR_SW_TRIG, {16'h0, 8'(part), 5'h0, idx});
      for (int t = 0; t < NC; t++) begin
        if (part[t]) begin
          exp_buf[t][EVT_SW_LSB + idx] = 1'b1;
        end
      end
      check_buffers();
    end
    for (int i = 0; i < NC; i++) begin
      wdata = rand_bits(8);
      write_reg(i, ADDR_CLEAR, wdata);
      exp_buf[i] = exp_buf[i] & ~wdata;
    end
    check_buffers();
    clear_all();
    check_buffers();

    // blocking wait woken by a software event from the next core
    w   = rand_bits(3) % NC;
    s   = (w + 1) % NC;
    idx = sw_evt_id_t'(rand_bits(3));
    write_reg(w, ADDR_MASK, 32'(1) << idx);
    fork
      bus_access(w, 1'b0, ADDR_WAIT, '0, WAIT_LIMIT, rd);
      begin
        repeat (3) next_cycle();
        check_value("clock enable of a sleeping core", core_clock_en[w], 0);
        check_value("ack of a sleeping core", core_rsp[w].ack, 0);
        write_reg(s, ADDR_SW_TRIG, {16'h0, 8'(1 << w), 5'h0, idx});
      end
    join
    check_value("wait read data", rd, 32'(1) << idx);
    check_value("clock enables after wake-up", core_clock_en, {NC{1'b1}});
    check_buffers();

    // hardware barrier where every core triggers but only participants count
    b    = rand_bits(3) % `EU_NB_BARR;
    part = core_mask_t'(rand_bits(NC));
    if (part == '0) begin
      part = 1;
    end
    write_reg(PERIPH, eu_addr_t'(b), 32'(part));
    expect_reg(PERIPH, eu_addr_t'(b), 32'(part), "barrier participant mask");
    left = $countones(part);
    for (int i = 0; i < NC; i++) begin
      write_reg(i, ADDR_BARR_TRIG, 32'(b));
      if (part[i]) begin
        left--;
      end
      if (left == 0) begin
        for (int t = 0; t < NC; t++) begin
          exp_buf[t][EVT_BARR_LSB + b] = part[t];
        end
      end
      check_buffers();
    end
    clear_all();

    // SoC FIFO is filled until back-pressure and then popped in order
    n = 0;
    while (soc_ready) begin
      soc_valid = 1'b1;
      soc_id    = evt_id_t'(rand_bits(`EU_EVT_ID_W));
      fifo_q.push_back(soc_id);
      next_cycle();
      n++;
      if (n > `EU_FIFO_DEPTH + 4) begin
        abort_run("SoC ready never fell while the FIFO was being filled");
      end
    end
    soc_valid = 1'b0;
    check_value("words accepted before ready fell", n, `EU_FIFO_DEPTH);
    for (int i = 0; i < NC; i++) begin
      exp_buf[i][EVT_FIFO_BIT] = 1'b1;
    end
    check_buffers();
    while (fifo_q.size() > 0) begin
      expect_reg(PERIPH, ADDR_FIFO_POP, 32'h8000_0000 | 32'(fifo_q.pop_front()),
                 "popped SoC event");
    end
    expect_reg(PERIPH, ADDR_FIFO_POP, '0, "pop from the empty FIFO");
    check_value("SoC ready after draining", soc_ready, 1);
    clear_all();
    check_buffers();

    // cluster event pulses reach only their own core
    for (int i = 0; i < 3; i++) begin
      c = rand_bits(3) % NC;
      k = rand_bits(4) % 15;
      cluster_ev[c][k] = 1'b1;
      next_cycle();
      cluster_ev = '0;
      exp_buf[c][EVT_CLUSTER_LSB + k] = 1'b1;
      check_buffers();
      clear_all();
    end
    check_buffers();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hw
hw/event_unit_pkg.sv
hw/eu_bus_pkg.sv
hw/event_unit_core.sv
hw/hw_barrier_unit.sv
hw/soc_periph_fifo.sv
hw/eu_periph_demux.sv
hw/event_unit_top.sv
tests/tb_event_unit.sv

// File: Bender.yml
package:
  name: event_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/event_unit_pkg.sv
      - hw/eu_bus_pkg.sv
      - hw/event_unit_core.sv
      - hw/hw_barrier_unit.sv
      - hw/soc_periph_fifo.sv
      - hw/eu_periph_demux.sv
      - hw/event_unit_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_event_unit.sv
